// ==== include/i2cBlock_params.svh ====
// Build-time constants of the I2C keypad block
// Include in RTL and testbench files that need the map or the poll timing
`ifndef I2C_BLOCK_PARAMS_SVH
`define I2C_BLOCK_PARAMS_SVH

//----------------------------------------------------------------------
// Bus map
//----------------------------------------------------------------------
`define I2C_BLOCK_ADRS    8'h04		// Compared with adrs[23:16]

// CSR offsets in adrs[15:0]
`define I2C_CSR_ENABLE    16'h0000	// bit 0 starts polling
`define I2C_CSR_DIV       16'h0004	// Quarter-bit divider
`define I2C_CSR_KEYPAD    16'h0008	// Last keypad word, read only
`define I2C_CSR_STATUS    16'h000C	// bit 0 busy, bit 1 ackError

//----------------------------------------------------------------------
// I2C side
//----------------------------------------------------------------------
`define I2C_DIV_BITS      16		// Divider register width
`define I2C_KEYPAD_ADDR   7'h20		// Expander slave address
`define I2C_POLL_GAP      64		// Clocks between STOP and next START

`endif

// ==== design/i2cPkg.sv ====
// Shared types of the I2C keypad block
// Bus command field, bit-engine command and poller state encodings
package i2cPkg;

	//----------------------------------------------------------------------
	// Bus command, address bits 31:30
	//----------------------------------------------------------------------
	typedef enum logic [1:0] {
		cmdNone      = 2'd0,	// No access
		cmdWrite     = 2'd1,	// Register write
		cmdRead      = 2'd2,	// Register read, answered with vd
		cmdWriteRead = 2'd3		// Reserved, decoded and dropped
	} busCmdT;

	//----------------------------------------------------------------------
	// Bit-engine command, one per go strobe
	//----------------------------------------------------------------------
	typedef enum logic [1:0] {
		bitStart = 2'd0,	// SDA falls while SCL high
		bitStop  = 2'd1,	// SDA rises while SCL high
		bitWrite = 2'd2,	// 8 bits out, slave ACK in
		bitRead  = 2'd3		// 8 bits in, master ACK out
	} bitCmdT;

	// Keypad poll sequence
	typedef enum logic [2:0] {
		psIdle   = 3'd0,
		psStart  = 3'd1,
		psAddr   = 3'd2,	// Slave address with read bit
		psReadHi = 3'd3,	// Upper keypad byte, ACKed
		psReadLo = 3'd4,	// Lower keypad byte, NACKed
		psStop   = 3'd5,
		psGap    = 3'd6		// Idle time between polls
	} pollStateT;

endpackage

// ==== design/i2cBitEngine.sv ====
// I2C master bit sequencer with SCL divider and open-drain SDA control
// Runs one START, STOP, byte write or byte read per go strobe and pulses done
`include "i2cBlock_params.svh"

module i2cBitEngine (
	input  logic                     sysClk,
	input  logic                     reset,
	input  logic [`I2C_DIV_BITS-1:0] div,		// Quarter-bit length minus one
	input  logic                     go,		// One-cycle command strobe
	input  i2cPkg::bitCmdT           cmd,
	input  logic [7:0]               txByte,
	input  logic                     ack,		// Master ACK for reads, 0 = ACK
	output logic                     done,
	output logic [7:0]               rxByte,
	output logic                     rxAck,		// ACK bit seen on the 9th clock
	output logic                     scl,
	output logic                     sdaLow,	// 1 pulls SDA down
	input  logic                     sdaIn
);

import i2cPkg::*;

bitCmdT                   cmdR;
logic [7:0]               txR;
logic                     ackR;
logic                     busy;
logic [`I2C_DIV_BITS-1:0] divCnt;
logic [1:0]               quarter;		// Phase inside one bit
logic [3:0]               bitCnt;		// 0..8, 8 is the ACK slot
logic                     tick;
logic                     lastBit;
logic                     dataCmd;
logic [1:0]               nextQ;
logic [3:0]               nextBit;
logic                     sclNext;
logic                     sdaLowNext;

// SCL level per quarter
function automatic logic sclFor(input bitCmdT c, input logic [1:0] q);
	case (c)
		bitStart: return q != 2'd3;		// Low at the end, ready for data
		bitStop:  return q != 2'd0;
		default:  return (q == 2'd1) || (q == 2'd2);
	endcase
endfunction

// SDA pull-down per quarter and bit
function automatic logic sdaLowFor(input bitCmdT c, input logic [1:0] q,
	input logic [3:0] b, input logic txBit, input logic ackBit);
	case (c)
		bitStart: return q != 2'd0;		// Falls in quarter 1
		bitStop:  return q < 2'd2;		// Rises in quarter 2
		bitWrite: return (b == 4'd8) ? 1'b0 : ~txBit;	// Release for slave ACK
		default:  return (b == 4'd8) ? ~ackBit : 1'b0;
	endcase
endfunction

//----------------------------------------------------------------------
// Next quarter decode
//----------------------------------------------------------------------
assign tick    = busy && (divCnt >= div);	// >= survives a divider shrink
assign dataCmd = (cmdR == bitWrite) || (cmdR == bitRead);

always_comb
begin
	lastBit    = !dataCmd || (bitCnt == 4'd8);
	nextQ      = quarter + 2'd1;
	nextBit    = (quarter == 2'd3) ? bitCnt + 4'd1 : bitCnt;
	sclNext    = sclFor(cmdR, nextQ);
	sdaLowNext = sdaLowFor(cmdR, nextQ, nextBit, txR[3'd7 - nextBit[2:0]], ackR);
end

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		busy    <= 1'b0;
		done    <= 1'b0;
		divCnt  <= '0;
		quarter <= 2'd0;
		bitCnt  <= 4'd0;
		scl     <= 1'b1;	// Bus idle
		sdaLow  <= 1'b0;
	end
	else
	begin
		done <= 1'b0;
		if (go && !busy)
		begin
			busy    <= 1'b1;
			divCnt  <= '0;
			quarter <= 2'd0;
			bitCnt  <= 4'd0;
			scl     <= sclFor(cmd, 2'd0);
			sdaLow  <= sdaLowFor(cmd, 2'd0, 4'd0, txByte[7], ack);
		end
		else if (tick)
		begin
			divCnt <= '0;
			if ((quarter == 2'd3) && lastBit)
			begin
				busy <= 1'b0;	// Lines keep their last level
				done <= 1'b1;
			end
			else
			begin
				quarter <= nextQ;
				bitCnt  <= nextBit;
				scl     <= sclNext;
				sdaLow  <= sdaLowNext;
			end
		end
		else if (busy)
			divCnt <= divCnt + 1'b1;
	end
end

// Command latch and SDA sampling at mid SCL high
always_ff @(posedge sysClk)
begin
	if (go && !busy)
	begin
		cmdR <= cmd;
		txR  <= txByte;
		ackR <= ack;
	end
	if (tick && (quarter == 2'd1) && dataCmd)
	begin
		if (bitCnt == 4'd8)
			rxAck <= sdaIn;
		else
			rxByte <= {rxByte[6:0], sdaIn};	// MSB first
	end
end

// Poller must wait for done before the next go
goWhileIdle: assert property (@(posedge sysClk) disable iff (reset) go |-> !busy)
	else $error("bit engine got go while busy");

// Every command starts from the SCL level the previous one left
sclSteadyOnGo: assert property (@(posedge sysClk) disable iff (reset) go |=> $stable(scl))
	else $error("SCL moved on command start");

endmodule

// ==== design/i2cKeyPadPoller.sv ====
// Keypad poll sequencer on top of the bit engine
// START, address+read, two data bytes, STOP, then a gap while enabled
`include "i2cBlock_params.svh"

module i2cKeyPadPoller (
	input  logic           sysClk,
	input  logic           reset,
	input  logic           enable,
	output logic           go,
	output i2cPkg::bitCmdT cmd,
	output logic [7:0]     txByte,
	output logic           ack,
	input  logic           done,
	input  logic [7:0]     rxByte,
	input  logic           rxAck,
	output logic [15:0]    keyPad,
	output logic           keyValid,	// One cycle with a new keyPad
	output logic           busy,
	output logic           ackError
);

import i2cPkg::*;

localparam int GapBits = $clog2(`I2C_POLL_GAP + 1);

pollStateT          state;
logic               issued;		// Command of this state sent
logic               nackSeen;	// Address not acknowledged in this poll
logic [GapBits-1:0] gapCnt;
logic [7:0]         hiByte;
logic [7:0]         loByte;

//----------------------------------------------------------------------
// Command per state
//----------------------------------------------------------------------
assign busy = (state != psIdle) && (state != psGap);
assign go   = busy && !issued;		// Once on state entry

always_comb
begin
	cmd    = bitStart;
	txByte = 8'h00;
	ack    = 1'b1;
	case (state)
		psStop:   cmd = bitStop;
		psAddr:
		begin
			cmd    = bitWrite;
			txByte = {`I2C_KEYPAD_ADDR, 1'b1};	// R/W = read
		end
		psReadHi:
		begin
			cmd = bitRead;
			ack = 1'b0;		// More data wanted
		end
		psReadLo: cmd = bitRead;	// NACK ends the read
		default:  cmd = bitStart;
	endcase
end

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		state    <= psIdle;
		issued   <= 1'b0;
		nackSeen <= 1'b0;
		gapCnt   <= '0;
		keyPad   <= 16'h0000;
		keyValid <= 1'b0;
		ackError <= 1'b0;
	end
	else
	begin
		keyValid <= 1'b0;
		if (go)
			issued <= 1'b1;
		if (done)
			issued <= 1'b0;
		case (state)
			psIdle:
				if (enable)
				begin
					state    <= psStart;
					nackSeen <= 1'b0;
				end
			psStart:  if (done) state <= psAddr;
			psAddr:
				if (done)
				begin
					nackSeen <= rxAck;
					state    <= rxAck ? psStop : psReadHi;	// No slave, close bus
				end
			psReadHi: if (done) state <= psReadLo;
			psReadLo: if (done) state <= psStop;
			psStop:
				if (done)
				begin
					state    <= psGap;
					gapCnt   <= '0;
					ackError <= nackSeen;
					if (!nackSeen)
					begin
						keyPad   <= {hiByte, loByte};
						keyValid <= 1'b1;
					end
				end
			default:	// psGap
				if (gapCnt == GapBits'(`I2C_POLL_GAP - 1))
				begin
					state    <= enable ? psStart : psIdle;
					nackSeen <= 1'b0;
				end
				else
					gapCnt <= gapCnt + 1'b1;
		endcase
	end
end

// Data bytes
always_ff @(posedge sysClk)
begin
	if (done && (state == psReadHi))
		hiByte <= rxByte;
	if (done && (state == psReadLo))
		loByte <= rxByte;
end

// One command in flight at a time
goOnlyAfterDone: assert property (@(posedge sysClk) disable iff (reset)
	go |=> (!go until_with done))
	else $error("poller issued go before done");

endmodule

// ==== design/i2cCsr.sv ====
// Bus slave register file of the I2C keypad block
// Enable and divider are read/write; keypad and status are read only
`include "i2cBlock_params.svh"

module i2cCsr (
	input  logic                     sysClk,
	input  logic                     reset,
	output logic [31:0]              rd,
	output logic                     vd,		// Read data valid, one cycle
	input  logic [31:0]              wd,
	input  logic [31:0]              adrs,		// Cmd, block and CSR offset
	input  logic                     wCke,		// Command strobe
	output logic                     enable,
	output logic [`I2C_DIV_BITS-1:0] div,
	input  logic [15:0]              keyPad,
	input  logic                     keyValid,
	input  logic                     busy,
	input  logic                     ackError
);

import i2cPkg::*;

busCmdT      busCmd;
logic        blockHit;
logic        wrEn;
logic        rdEn;
logic [15:0] csrOffset;
logic [15:0] keyPadReg;
logic [31:0] readData;

//----------------------------------------------------------------------
// Command decode
//----------------------------------------------------------------------
assign busCmd    = busCmdT'(adrs[31:30]);
assign blockHit  = wCke && (adrs[23:16] == `I2C_BLOCK_ADRS);
assign csrOffset = adrs[15:0];

always_comb
begin
	wrEn = 1'b0;
	rdEn = 1'b0;
	case (busCmd)
		cmdWrite: wrEn = blockHit;
		cmdRead:  rdEn = blockHit;
		default:  ;		// cmdNone, reserved cmdWriteRead
	endcase
end

// Read mux, unknown offsets give zero
always_comb
begin
	case (csrOffset)
		`I2C_CSR_ENABLE: readData = {31'd0, enable};
		`I2C_CSR_DIV:    readData = {{(32 - `I2C_DIV_BITS){1'b0}}, div};
		`I2C_CSR_KEYPAD: readData = {16'h0000, keyPadReg};
		`I2C_CSR_STATUS: readData = {30'd0, ackError, busy};
		default:         readData = 32'h0000_0000;
	endcase
end

always_ff @(posedge sysClk)
begin
	if (reset)
	begin
		enable    <= 1'b0;
		div       <= '0;
		keyPadReg <= 16'h0000;
		vd        <= 1'b0;
	end
	else
	begin
		vd <= rdEn;
		if (wrEn && (csrOffset == `I2C_CSR_ENABLE))
			enable <= wd[0];
		if (wrEn && (csrOffset == `I2C_CSR_DIV))
			div <= wd[`I2C_DIV_BITS-1:0];
		if (keyValid)
			keyPadReg <= keyPad;	// Holds between polls
	end
end

always_ff @(posedge sysClk)
begin
	if (rdEn)
		rd <= readData;
end

// Back-to-back read strobes only for back-to-back reads
vdFromReads: assert property (@(posedge sysClk) disable iff (reset)
	(vd && $past(vd)) |-> ($past(wCke) && $past(wCke, 2)))
	else $error("vd held without matching read commands");

endmodule

// ==== design/i2cBlock.sv ====
// Top of the I2C keypad block on the internal bus
// Register slave, keypad poller and bit engine behind one block address
`include "i2cBlock_params.svh"

module i2cBlock (
	input  logic        sysClk,
	input  logic        reset,
	// I2C pins
	output logic        scl,
	inout  wire         sda,		// Open drain, pull-up outside
	// Bus slave
	output logic [31:0] rd,
	output logic        vd,
	input  logic [31:0] wd,
	input  logic [31:0] adrs,
	input  logic        wCke
);

import i2cPkg::*;

//----------------------------------------------------------------------
// Internal nets
//----------------------------------------------------------------------
logic                     enable;
logic [`I2C_DIV_BITS-1:0] div;
logic [15:0]              keyPad;
logic                     keyValid;
logic                     busy;
logic                     ackError;
logic                     go;
bitCmdT                   cmd;
logic [7:0]               txByte;
logic                     ack;
logic                     done;
logic [7:0]               rxByte;
logic                     rxAck;
logic                     sdaLow;

assign sda = sdaLow ? 1'b0 : 1'bz;	// Pull low or release

i2cCsr i2cCsr_inst (
	.sysClk(sysClk), .reset(reset),
	.rd(rd), .vd(vd), .wd(wd), .adrs(adrs), .wCke(wCke),
	.enable(enable), .div(div),
	.keyPad(keyPad), .keyValid(keyValid), .busy(busy), .ackError(ackError)
);

i2cKeyPadPoller i2cKeyPadPoller_inst (
	.sysClk(sysClk), .reset(reset), .enable(enable),
	.go(go), .cmd(cmd), .txByte(txByte), .ack(ack),
	.done(done), .rxByte(rxByte), .rxAck(rxAck),
	.keyPad(keyPad), .keyValid(keyValid), .busy(busy), .ackError(ackError)
);

i2cBitEngine i2cBitEngine_inst (
	.sysClk(sysClk), .reset(reset), .div(div),
	.go(go), .cmd(cmd), .txByte(txByte), .ack(ack),
	.done(done), .rxByte(rxByte), .rxAck(rxAck),
	.scl(scl), .sdaLow(sdaLow), .sdaIn(sda)
);

endmodule

// ==== tests/i2cKeyPadModel.sv ====
// Behavioral 16-bit keypad I/O expander on the I2C bus
// Answers address+read with two data bytes and counts START and STOP conditions
`include "i2cBlock_params.svh"

module i2cKeyPadModel (
	input  logic        scl,
	inout  wire         sda,
	input  logic [15:0] keyValue,		// Word returned by the next read
	input  logic        nack,			// 1 leaves the address unacknowledged
	output int          startCount,
	output int          stopCount
);

timeunit 1ns;
timeprecision 100ps;

logic       drive;		// 1 pulls SDA low
int         rises;		// SCL rising edges since START
logic [7:0] addrShift;
logic       addrOk;

assign sda = drive ? 1'b0 : 1'bz;

initial
begin
	drive      = 1'b0;
	rises      = 0;
	addrShift  = 8'h00;
	addrOk     = 1'b0;
	startCount = 0;
	stopCount  = 0;
end

//----------------------------------------------------------------------
// START and STOP, SDA edges while SCL high
//----------------------------------------------------------------------
always @(negedge sda)
begin
	if (scl === 1'b1)
	begin
		startCount++;
		rises  = 0;		// New frame
		drive  = 1'b0;
		addrOk = 1'b0;
	end
end

always @(posedge sda)
begin
	if (scl === 1'b1)
		stopCount++;
end

// Address bits are rises 1..8
always @(posedge scl)
begin
	rises++;
	if ((rises >= 1) && (rises <= 8))
		addrShift = {addrShift[6:0], (sda !== 1'b0)};
end

// Next bit goes out while SCL is low
always @(negedge scl)
begin : nextBit
	int r;
	r = rises + 1;
	if (r == 9)
	begin
		addrOk = (addrShift == {`I2C_KEYPAD_ADDR, 1'b1}) && !nack;
		drive  = addrOk;		// Address ACK
	end
	else if (addrOk && (r >= 10) && (r <= 17))
		drive = !keyValue[25 - r];	// High byte, MSB first
	else if (addrOk && (r >= 19) && (r <= 26))
		drive = !keyValue[26 - r];	// Low byte
	else
		drive = 1'b0;		// Master ACK slots and idle
end

endmodule

// ==== tests/i2cBlockChecker.sv ====
// Result checker of the I2C block testbench
// Compares bus read data and SCL high phases, prints one line per test
module i2cBlockChecker (
	input logic        sysClk,
	input logic        vd,
	input logic [31:0] rd,
	input logic        scl
);

timeunit 1ns;
timeprecision 100ps;

int tests      = 0;
int errors     = 0;
bit timingOn   = 1'b0;
int expHigh    = 2;		// SCL high of a data bit in clocks
int highLen    = 0;
int dataPhases = 0;
int badPhases  = 0;
int badLen     = 0;

// SCL high phases, sampled on the falling clock
always @(negedge sysClk)
begin
	if (scl === 1'b1)
		highLen++;
	else
	begin
		// START and STOP highs last 3 quarters or more
		if (timingOn && (highLen > 0) && (2 * highLen < 3 * expHigh))
		begin
			dataPhases++;
			if (highLen != expHigh)
			begin
				badPhases++;
				badLen = highLen;
			end
		end
		highLen = 0;
	end
end

task automatic result(input string name, input bit ok);
	tests++;
	if (ok)
		$display("pass %s", name);
	else
		errors++;
endtask

//----------------------------------------------------------------------
// Bus reads, called right after the strobe cycle
//----------------------------------------------------------------------
task automatic checkRead(input string name, input logic [31:0] exp);
	@(negedge sysClk);
	if (vd !== 1'b1)
		$display("%s failed: no read strobe one cycle after the command", name);
	else if (rd !== exp)
		$display("error %s expected %h actual %h", name, exp, rd);
	result(name, (vd === 1'b1) && (rd === exp));
endtask

task automatic checkNoRead(input string name);
	bit seen;
	seen = 1'b0;
	repeat (3)
	begin
		@(negedge sysClk);
		if (vd !== 1'b0)
			seen = 1'b1;
	end
	if (seen)
		$display("%s failed: a read strobe came from another block address", name);
	result(name, !seen);
endtask

task automatic checkTrue(input string name, input bit ok, input string what);
	if (!ok)
		$display("%s failed: %s", name, what);
	result(name, ok);
endtask

// SCL timing window
task automatic timingStart(input int div);
	expHigh    = 2 * (div + 1);
	dataPhases = 0;
	badPhases  = 0;
	timingOn   = 1'b1;
endtask

task automatic timingCheck(input string name, input int minPhases);
	timingOn = 1'b0;
	if (badPhases > 0)
		$display("error %s expected %0d actual %0d", name, expHigh, badLen);
	else if (dataPhases < minPhases)
		$display("%s failed: only %0d data bits seen on SCL", name, dataPhases);
	result(name, (badPhases == 0) && (dataPhases >= minPhases));
endtask

task automatic reportCounts();
	$display("%0d tests, %0d passed, %0d failed", tests, tests - errors, errors);
endtask

endmodule

// ==== tests/i2cBlockTb.sv ====
// Testbench top of the I2C keypad block
// Runs the steps of the data file against the DUT, the keypad model and the checker
`include "i2cBlock_params.svh"

module i2cBlockTb;

timeunit 1ns;
timeprecision 100ps;

import i2cPkg::*;

logic        sysClk;
logic        reset;
logic [31:0] wd;
logic [31:0] adrs;
logic        wCke;
logic [31:0] rd;
logic        vd;
logic        scl;
wire         sda;
logic [15:0] modelKey;
logic        modelNack;
int          startCount;
int          stopCount;
logic [31:0] lcgState;
logic [15:0] goodKey;		// Last key a full acked poll returned
int          curDiv;
int          cycles;
int          limit;
string       opQ[$];
string       nameQ[$];
logic [31:0] aQ[$];
logic [31:0] bQ[$];
logic [31:0] cQ[$];

pullup (sda);

i2cBlock i2cBlock_inst (
	.sysClk(sysClk), .reset(reset), .scl(scl), .sda(sda),
	.rd(rd), .vd(vd), .wd(wd), .adrs(adrs), .wCke(wCke)
);

i2cKeyPadModel keyPad_inst (
	.scl(scl), .sda(sda), .keyValue(modelKey), .nack(modelNack),
	.startCount(startCount), .stopCount(stopCount)
);

i2cBlockChecker checker_inst (.sysClk(sysClk), .vd(vd), .rd(rd), .scl(scl));

always #2 sysClk = ~sysClk;	// 4 ns period

// Run limit
always @(posedge sysClk)
begin
	cycles <= cycles + 1;
	if (cycles > limit)
	begin
		$display("timeout: the run went past %0d clock cycles", limit);
		$display("TESTS FAILED");
		$finish;
	end
end

function automatic logic [31:0] lcgNext(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

//----------------------------------------------------------------------
// Bus commands
//----------------------------------------------------------------------
task automatic busCmd(input busCmdT c, input logic [7:0] blk, input logic [15:0] off,
	input logic [31:0] data);
	@(posedge sysClk);
	wCke <= 1'b1;
	adrs <= {c, 6'd0, blk, off};
	wd   <= data;
	@(posedge sysClk);
	wCke <= 1'b0;		// Single-cycle strobe
	adrs <= 32'h0;
endtask

task automatic waitStops(input int count);
	int base;
	base = stopCount;
	while (stopCount < base + count)
		@(posedge sysClk);
endtask

task automatic runStep(input string op, input string name, input logic [31:0] a,
	input logic [31:0] b, input logic [31:0] c);
	int sBase;
	int tBase;
	case (op)
		"W":
		begin
			busCmd(cmdWrite, `I2C_BLOCK_ADRS, a[15:0], b);
			if (a[15:0] == `I2C_CSR_DIV)
				curDiv = b;
		end
		"R":
		begin
			busCmd(cmdRead, `I2C_BLOCK_ADRS, a[15:0], 32'h0);
			checker_inst.checkRead(name, c);
		end
		"RK":
		begin
			busCmd(cmdRead, `I2C_BLOCK_ADRS, `I2C_CSR_KEYPAD, 32'h0);
			checker_inst.checkRead(name, {16'h0000, goodKey});
		end
		"X":
		begin
			busCmd(cmdRead, a[7:0], `I2C_CSR_ENABLE, 32'h0);
			checker_inst.checkNoRead(name);
		end
		"K":  modelKey = b[15:0];
		"KR":
		begin
			lcgState = lcgNext(lcgState);
			modelKey = lcgState[31:16];	// Upper bits are the better ones
		end
		"N":  modelNack = a[0];
		"S":
		begin
			waitStops(a);
			if ((a >= 2) && !modelNack)
				goodKey = modelKey;	// Second poll read the whole new word
			repeat (4 * (curDiv + 1) + 4) @(posedge sysClk);	// Past STOP done
		end
		"T":
		begin
			busCmd(cmdWrite, `I2C_BLOCK_ADRS, `I2C_CSR_DIV, a);
			curDiv = a;
			waitStops(1);		// Poll under the old divider ends
			checker_inst.timingStart(curDiv);
			waitStops(2);
			checker_inst.timingCheck(name, 54);	// 27 data bits per poll
		end
		"D":
		begin
			sBase = stopCount;
			tBase = startCount;
			repeat (3 * (80 * (curDiv + 1) + `I2C_POLL_GAP)) @(posedge sysClk);
			checker_inst.checkTrue(name,
				(stopCount - sBase <= 1) && (startCount - tBase <= stopCount - sBase),
				"the bus kept polling after enable was cleared");
		end
		default: checker_inst.checkTrue(name, 1'b0, "unknown operation in the data file");
	endcase
endtask

// Data file into step queues and run limit from the dividers
task automatic loadSteps(input int fd);
	string line;
	string op;
	string name;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	int d;
	d     = 0;
	limit = 40;		// Reset and drain
	while ($fgets(line, fd))
	begin
		if ((line.len() > 1) && (line[0] != "#") &&
			($sscanf(line, "%s %s %h %h %h", op, name, a, b, c) == 5))
		begin
			opQ.push_back(op);
			nameQ.push_back(name);
			aQ.push_back(a);
			bQ.push_back(b);
			cQ.push_back(c);
			if ((op == "W") && (a[15:0] == `I2C_CSR_DIV))
				d = b;
			if (op == "T")
				d = a;
			limit += 3 * (80 * (d + 1) + `I2C_POLL_GAP);
		end
	end
endtask

initial
begin : main
	int fd;
	sysClk    = 1'b0;
	reset     = 1'b1;
	wd        = 32'h0;
	adrs      = 32'h0;
	wCke      = 1'b0;
	modelKey  = 16'h0000;
	modelNack = 1'b0;
	lcgState  = 32'h215e_88b8;
	goodKey   = 16'h0000;
	curDiv    = 0;
	cycles    = 0;
	limit     = 0;
	fd = $fopen("tests/i2cBlock_testdata.txt", "r");
	if (fd == 0)
	begin
		$display("could not open the test data file");
		$display("TESTS FAILED");
		$finish;
	end
	else
	begin
		loadSteps(fd);
		$fclose(fd);
		repeat (4) @(posedge sysClk);
		reset <= 1'b0;
		foreach (opQ[i])
			runStep(opQ[i], nameQ[i], aQ[i], bQ[i], cQ[i]);
		repeat (4) @(posedge sysClk);
		checker_inst.reportCounts();
		if (checker_inst.errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
end

endmodule

// ==== tests/i2cBlock_testdata.txt ====
# op name a b c, hex fields. W/R: offset data expected. X: block address.
# K: - key. KR: random key. N: nack. S: STOPs to wait. T: divider. RK/D: none.
W divWrite 0004 3 0
R divRead 0004 0 3
X otherBlock 05 0 0
KR keyRandom 0 0 0
W enWrite 0000 1 0
R enRead 0000 0 1
S pollRandom 2 0 0
RK keyRandomRead 0 0 0
K keyFixed 0 a5c3 0
S pollFixed 2 0 0
RK keyFixedRead 0 0 0
N nackOn 1 0 0
S pollNack 2 0 0
R nackStatus 000C 0 2
RK nackKeyRead 0 0 0
N nackOff 0 0 0
T sclDiv0 0 0 0
T sclDiv7 7 0 0
R unknownOffset 0010 0 0
W disable 0000 0 0
D disableWatch 0 0 0
R idleStatus 000C 0 0

// ==== all.f ====
+incdir+include
design/i2cPkg.sv
design/i2cBitEngine.sv
design/i2cKeyPadPoller.sv
design/i2cCsr.sv
design/i2cBlock.sv
tests/i2cKeyPadModel.sv
tests/i2cBlockChecker.sv
tests/i2cBlockTb.sv
